// File: project.f
source/operand_pkg.sv
source/pipeline_pkg.sv
source/cla_adder.sv
source/partial_product_stage.sv
source/adder_tree.sv
source/sign_accumulate.sv
source/mac_pe.sv
testbench/mac_pe_sva.sv
testbench/mac_pe_checker.sv
testbench/mac_pe_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module mac_pe_tb -o mac_pe_sim

./obj_dir/mac_pe_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation reported failures"
  exit 1
fi

echo "Simulation finished without failures"

// File: source/adder_tree.sv
// Six level registered shift-and-add tree reducing eight partial products to a magnitude
`timescale 1ns/1ps
`default_nettype none

module adder_tree
  import operand_pkg::*, pipeline_pkg::*;
(
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         en,
  input  magnitude_t [OPERAND_W-1:0]   pp,
  input  logic                         sign,
  input  logic                         first,
  output product_t                     magnitude,
  output logic                         sign_q,
  output logic                         first_q
);

  // Round one, pp[2n] + 2*pp[2n+1]
  logic [5:0]  l1_lo   [4];
  logic [2:0]  l1_hi_e [4];
  logic [3:0]  l1_hi_o [4];
  logic [4:0]  l2_hi   [4];
  pair_sum_t   l2_pair [4];

  // Round two, pair[2m] + 4*pair[2m+1]
  logic [7:0]  l3_lo   [2];
  logic [2:0]  l3_hi_e [2];
  logic [4:0]  l3_hi_o [2];
  logic [4:0]  l4_hi   [2];
  quad_sum_t   l4_quad [2];

  // Round three, quad[0] + 16*quad[1]
  logic [9:0]  l5_lo;
  logic [2:0]  l5_hi_e;
  logic [6:0]  l5_hi_o;
  logic [6:0]  l6_hi;

  logic [TREE_LEVELS-1:0] sign_pipe;
  logic [TREE_LEVELS-1:0] first_pipe;

  ////////////////////////////////////////////////////////////////////////////
  // High parts, each adding the carry registered by the low part
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int n = 0; n < 4; n++) begin
      l2_hi[n] = {2'b0, l1_hi_e[n]} + {1'b0, l1_hi_o[n]} + {4'b0, l1_lo[n][5]};
    end
    for (int m = 0; m < 2; m++) begin
      l4_hi[m] = {2'b0, l3_hi_e[m]} + l3_hi_o[m] + {4'b0, l3_lo[m][7]};
    end
    l6_hi = {4'b0, l5_hi_e} + l5_hi_o + {6'b0, l5_lo[9]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data levels
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (en) begin
      // Level 1, low part of each pair and its upper bits
      for (int n = 0; n < 4; n++) begin
        l1_lo[n]   <= {1'b0, pp[2*n][4:0]} + {1'b0, pp[2*n+1][3:0], 1'b0};
        l1_hi_e[n] <= pp[2*n][7:5];
        l1_hi_o[n] <= pp[2*n+1][7:4];
      end

      // Level 2, complete pair sums
      for (int n = 0; n < 4; n++) begin
        l2_pair[n] <= {l2_hi[n], l1_lo[n][4:0]};
      end

      // Level 3, low part of each quad
      for (int m = 0; m < 2; m++) begin
        l3_lo[m]   <= {1'b0, l2_pair[2*m][6:0]} + {1'b0, l2_pair[2*m+1][4:0], 2'b00};
        l3_hi_e[m] <= l2_pair[2*m][9:7];
        l3_hi_o[m] <= l2_pair[2*m+1][9:5];
      end

      // Level 4, complete quad sums
      for (int m = 0; m < 2; m++) begin
        l4_quad[m] <= {l4_hi[m], l3_lo[m][6:0]};
      end

      // Level 5, low part of the final sum
      l5_lo   <= {1'b0, l4_quad[0][8:0]} + {1'b0, l4_quad[1][4:0], 4'b0000};
      l5_hi_e <= l4_quad[0][11:9];
      l5_hi_o <= l4_quad[1][11:5];

      // Level 6, unsigned product
      magnitude <= {l6_hi, l5_lo[8:0]};
    end
  end

  // Sign travels with the data
  always_ff @(posedge clk) begin
    if (en) begin
      sign_pipe <= {sign_pipe[TREE_LEVELS-2:0], sign};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      first_pipe <= '0;
    end else if (en) begin
      first_pipe <= {first_pipe[TREE_LEVELS-2:0], first};
    end
  end

  assign sign_q  = sign_pipe[TREE_LEVELS-1];
  assign first_q = first_pipe[TREE_LEVELS-1];

endmodule

`default_nettype wire

// File: source/cla_adder.sv
// Carry lookahead adder over the accumulator width with grouped generate/propagate
`timescale 1ns/1ps
`default_nettype none

module cla_adder
  import operand_pkg::*, pipeline_pkg::*;
(
  input  acc_t x,
  input  acc_t y,
  output acc_t sum
);

  // Bit level generate, propagate and carry into each bit
  acc_t bit_g;
  acc_t bit_p;
  acc_t bit_c;

  // The top group's carry out is dropped, so it has no group terms
  logic [CLA_GROUPS-2:0] grp_g;
  logic [CLA_GROUPS-2:0] grp_p;
  logic [CLA_GROUPS-1:0] grp_c;

  // Group generate folded from the lowest bit upwards
  function automatic logic group_gen(input logic [CLA_GROUP_W-1:0] g,
                                     input logic [CLA_GROUP_W-1:0] p);
    logic gen;
    gen = 1'b0;
    for (int k = 0; k < CLA_GROUP_W; k++) begin
      gen = g[k] | (p[k] & gen);
    end
    return gen;
  endfunction

  assign bit_g = x & y;
  assign bit_p = x ^ y;

  // No carry in, addition only
  assign grp_c[0] = 1'b0;

  for (genvar i = 0; i < CLA_GROUPS; i++) begin : gen_group
    localparam int LSB = i * CLA_GROUP_W;

    if (i < CLA_GROUPS - 1) begin : gen_lookahead
      assign grp_p[i]   = &bit_p[LSB +: CLA_GROUP_W];
      assign grp_g[i]   = group_gen(bit_g[LSB +: CLA_GROUP_W], bit_p[LSB +: CLA_GROUP_W]);
      // Group lookahead chain
      assign grp_c[i+1] = grp_g[i] | (grp_p[i] & grp_c[i]);
    end

    // Carries inside the group start from the group carry
    assign bit_c[LSB] = grp_c[i];
    for (genvar j = 1; j < CLA_GROUP_W; j++) begin : gen_bit_carry
      assign bit_c[LSB+j] = bit_g[LSB+j-1] | (bit_p[LSB+j-1] & bit_c[LSB+j-1]);
    end
  end

  assign sum = bit_p ^ bit_c;

endmodule

`default_nettype wire

// File: source/mac_pe.sv
// Multiply-accumulate processing element built from its three pipeline stages
`timescale 1ns/1ps
`default_nettype none

module mac_pe
  import operand_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     en,
  input  logic     first,
  input  operand_t a,
  input  operand_t b,
  output operand_t a_out,
  output operand_t b_out,
  output acc_t     result
);

  magnitude_t [OPERAND_W-1:0] pp;
  logic                       pp_sign;
  logic                       pp_first;
  product_t                   tree_mag;
  logic                       tree_sign;
  logic                       tree_first;

  // Edge k, partial products and forwarding
  partial_product_stage partial_product_stage_inst (
    .clk     (clk),
    .rstn    (rstn),
    .en      (en),
    .first   (first),
    .a       (a),
    .b       (b),
    .pp      (pp),
    .sign    (pp_sign),
    .first_q (pp_first),
    .a_out   (a_out),
    .b_out   (b_out)
  );

  // Edges k+1 to k+6
  adder_tree adder_tree_inst (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .pp        (pp),
    .sign      (pp_sign),
    .first     (pp_first),
    .magnitude (tree_mag),
    .sign_q    (tree_sign),
    .first_q   (tree_first)
  );

  // Signed product at k+7, accumulator at k+8
  sign_accumulate sign_accumulate_inst (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .magnitude (tree_mag),
    .sign      (tree_sign),
    .first     (tree_first),
    .result    (result)
  );

endmodule

`default_nettype wire

// File: source/operand_pkg.sv
// Operand, product and accumulator widths with their vector types
`default_nettype none

package operand_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data path widths
  ////////////////////////////////////////////////////////////////////////////

  // Signed operand as fed into the PE
  localparam int OPERAND_W = 8;
  // Full product of two operands
  localparam int PRODUCT_W = 2 * OPERAND_W;
  // Running sum, wide enough for long accumulation runs
  localparam int ACC_W = 28;

  ////////////////////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////////////////////

  // Two's complement operand
  typedef logic [OPERAND_W-1:0] operand_t;
  // Unsigned magnitude of an operand, 128 fits for the -128 case
  typedef logic [OPERAND_W-1:0] magnitude_t;
  // Product, unsigned in the tree and signed after sign restore
  typedef logic [PRODUCT_W-1:0] product_t;
  // Accumulator value in two's complement
  typedef logic [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

// File: source/partial_product_stage.sv
// First PE stage with operand magnitudes, partial products, product sign and forwarding
`timescale 1ns/1ps
`default_nettype none

module partial_product_stage
  import operand_pkg::*;
(
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         en,
  input  logic                         first,
  input  operand_t                     a,
  input  operand_t                     b,
  output magnitude_t [OPERAND_W-1:0]   pp,
  output logic                         sign,
  output logic                         first_q,
  output operand_t                     a_out,
  output operand_t                     b_out
);

  magnitude_t                   a_mag;
  magnitude_t                   b_mag;
  magnitude_t [OPERAND_W-1:0]   pp_next;

  // Conditional two's complement, -128 maps to 0x80
  assign a_mag = a[OPERAND_W-1] ? ~a + OPERAND_W'(1) : a;
  assign b_mag = b[OPERAND_W-1] ? ~b + OPERAND_W'(1) : b;

  // Row i is a_mag gated by bit i of b_mag, weight 2**i applied in the tree
  for (genvar i = 0; i < OPERAND_W; i++) begin : gen_pp
    assign pp_next[i] = b_mag[i] ? a_mag : '0;
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (en) begin
      pp   <= pp_next;
      sign <= a[OPERAND_W-1] ^ b[OPERAND_W-1];
    end
  end

  // First flag and operands handed to the neighbouring PE
  always_ff @(posedge clk) begin
    if (!rstn) begin
      first_q <= 1'b0;
      a_out   <= '0;
      b_out   <= '0;
    end else if (en) begin
      first_q <= first;
      a_out   <= a;
      b_out   <= b;
    end
  end

endmodule

`default_nettype wire

// File: source/pipeline_pkg.sv
// Pipeline depth, lookahead grouping and adder tree partial sum types
`default_nettype none

package pipeline_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Schedule
  ////////////////////////////////////////////////////////////////////////////

  // Enabled edges from operand capture up to the accumulator update
  localparam int PIPE_LATENCY = 9;
  // Register levels between the partial products and the magnitude
  localparam int TREE_LEVELS = 6;

  ////////////////////////////////////////////////////////////////////////////
  // Carry lookahead adder
  ////////////////////////////////////////////////////////////////////////////

  // Bits per generate/propagate group
  localparam int CLA_GROUP_W = 4;
  // Groups covering the accumulator width
  localparam int CLA_GROUPS = 7;

  // Sum of two partial products, the second one shifted by one
  typedef logic [9:0] pair_sum_t;
  // Sum of four partial products, built from two pair sums
  typedef logic [11:0] quad_sum_t;

endpackage

`default_nettype wire

// File: source/sign_accumulate.sv
// Product sign restore and first-controlled accumulation through the lookahead adder
`timescale 1ns/1ps
`default_nettype none

module sign_accumulate
  import operand_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     en,
  input  product_t magnitude,
  input  logic     sign,
  input  logic     first,
  output acc_t     result
);

  product_t product;
  logic     first_q;
  acc_t     product_ext;
  acc_t     base;
  acc_t     acc_next;

  // Signed product, negated when the operand signs differ
  always_ff @(posedge clk) begin
    if (en) begin
      product <= sign ? ~magnitude + PRODUCT_W'(1) : magnitude;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      first_q <= 1'b0;
    end else if (en) begin
      first_q <= first;
    end
  end

  assign product_ext = {{(ACC_W-PRODUCT_W){product[PRODUCT_W-1]}}, product};

  // A first pair restarts the sum from its own product
  assign base = first_q ? '0 : result;

  cla_adder cla_adder_inst (
    .x   (product_ext),
    .y   (base),
    .sum (acc_next)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result <= '0;
    end else if (en) begin
      result <= acc_next;
    end
  end

endmodule

`default_nettype wire

// File: testbench/mac_input.txt
// Columns: en first a b expected reps, all hex, reps 0 ends the list
// expected is the 28-bit result after the pair, compared on its last repetition
// Sign combinations, each started by first
1 1 03 05 000000F 01
1 1 FD 05 FFFFFF1 01
1 1 03 FB FFFFFF1 01
1 1 FD FB 000000F 01
1 1 7F 7F 0003F01 01
1 1 80 80 0004000 01
1 1 80 7F FFFC080 01
1 1 00 80 0000000 01
1 1 FF FF 0000001 01
1 1 01 FF FFFFFFF 01
1 1 55 AA FFFE372 01
1 1 64 9C FFFD8F0 01
// Accumulation run with enable gaps, then a restart
1 1 0A 14 00000C8 01
1 0 F9 09 0000089 01
0 0 00 00 0000000 04
1 0 32 FD FFFFFF3 01
0 1 7F 7F 0000000 03
1 0 EC EC 0000183 01
1 1 06 07 000002A 01
1 0 02 03 0000030 01
// 200 pairs of -128 * -128 with a gap halfway
1 1 80 80 0004000 01
1 0 80 80 0194000 64
0 0 00 00 0000000 07
1 0 80 80 0320000 63
1 1 02 02 0000004 01
// Negative sum of 100 pairs of 127 * -128
1 1 7F 80 FFFC080 01
1 0 7F 80 FE73200 63
0 0 55 55 0000000 02
1 1 FE 03 FFFFFFA 01
1 0 05 05 0000013 01
// End of list
0 0 00 00 0000000 00

// File: testbench/mac_pe_checker.sv
// Scoreboard that aligns expected sums with the PE pipeline and checks forwarding
`timescale 1ns/1ps
`default_nettype none

module mac_pe_checker
  import operand_pkg::*, pipeline_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     en,
  input  operand_t a,
  input  operand_t b,
  input  operand_t a_out,
  input  operand_t b_out,
  input  acc_t     result,
  input  logic     line_valid,
  input  logic     check_en,
  input  acc_t     expected,
  output int       result_errors,
  output int       fwd_errors,
  output logic     idle
);

  // Pairs in flight, oldest at the front
  acc_t     exp_q [$];
  bit       chk_q [$];
  int       cap_q [$];
  int       en_count;
  int       cmp_count;
  logic     cmp_due;
  operand_t last_a;
  operand_t last_b;

  always @(posedge clk) begin
    if (!rstn) begin
      exp_q.delete();
      chk_q.delete();
      cap_q.delete();
      en_count      = 0;
      cmp_count     = 0;
      cmp_due       = 1'b0;
      last_a        = '0;
      last_b        = '0;
      result_errors = 0;
      fwd_errors    = 0;
      idle          = 1'b1;
    end else begin
      // Front pair was accumulated at the previous enabled edge
      if (cmp_due) begin
        if (chk_q[0] && (result !== exp_q[0])) begin
          result_errors++;
          $display("FAIL result: expected %h, got %h (result %0d)", exp_q[0], result, cmp_count);
        end
        cmp_count++;
        void'(exp_q.pop_front());
        void'(chk_q.pop_front());
        void'(cap_q.pop_front());
        cmp_due = 1'b0;
      end

      if (a_out !== last_a) begin
        fwd_errors++;
        $display("FAIL a_out: expected %h, got %h", last_a, a_out);
      end
      if (b_out !== last_b) begin
        fwd_errors++;
        $display("FAIL b_out: expected %h, got %h", last_b, b_out);
      end

      if (en) begin
        en_count++;
        last_a = a;
        last_b = b;
        if (line_valid) begin
          exp_q.push_back(expected);
          chk_q.push_back(check_en);
          cap_q.push_back(en_count);
        end
        // Capture edge counts as the first of PIPE_LATENCY
        if (cap_q.size() > 0 && (en_count - cap_q[0] == PIPE_LATENCY - 1)) begin
          cmp_due = 1'b1;
        end
      end

      idle = (exp_q.size() == 0) && !cmp_due;
    end
  end

endmodule

`default_nettype wire

// File: testbench/mac_pe_sva.sv
// Bound assertions for reset values, stall holding and operand forwarding of the PE
`timescale 1ns/1ps
`default_nettype none

module mac_pe_sva
  import operand_pkg::*;
(
  input logic     clk,
  input logic     rstn,
  input logic     en,
  input operand_t a,
  input operand_t b,
  input operand_t a_out,
  input operand_t b_out,
  input acc_t     result
);

  // Outputs are cleared one edge after a reset edge
  reset_clears: assert property (
    @(posedge clk) !rstn |=> (result == '0) && (a_out == '0) && (b_out == '0)
  ) else $error("result or forwarded operands not zero after reset");

  // A disabled edge holds every visible register
  stall_holds: assert property (
    @(posedge clk) disable iff (!rstn)
    !en |=> $stable(result) && $stable(a_out) && $stable(b_out)
  ) else $error("result or forwarded operands changed on a disabled edge");

  // Neighbour operands are one enabled edge late
  forward_follows: assert property (
    @(posedge clk) disable iff (!rstn)
    en |=> (a_out == $past(a)) && (b_out == $past(b))
  ) else $error("forwarded operands differ from the previous enabled operands");

endmodule

`default_nettype wire

// File: testbench/mac_pe_tb.sv
// Testbench top with clock, reset, file-driven stimulus, PE instance, checker and timeout
`timescale 1ns/1ps
`default_nettype none

module mac_pe_tb
  import operand_pkg::*, pipeline_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int MAX_LINES    = 64;
  // en, first, a, b, expected, reps
  localparam int COLS         = 6;

  logic        clk;
  logic        rstn;
  logic        en;
  logic        first;
  operand_t    a;
  operand_t    b;
  operand_t    a_out;
  operand_t    b_out;
  acc_t        result;
  logic        line_valid;
  logic        check_en;
  acc_t        expected;
  int          result_errors;
  int          fwd_errors;
  logic        idle;
  logic [31:0] stim [MAX_LINES*COLS];
  int          n_lines;
  int          applied;
  int          limit;
  int          cycles = 0;

  mac_pe mac_pe_inst (
    .clk    (clk),
    .rstn   (rstn),
    .en     (en),
    .first  (first),
    .a      (a),
    .b      (b),
    .a_out  (a_out),
    .b_out  (b_out),
    .result (result)
  );

  mac_pe_checker mac_pe_checker_inst (
    .clk           (clk),
    .rstn          (rstn),
    .en            (en),
    .a             (a),
    .b             (b),
    .a_out         (a_out),
    .b_out         (b_out),
    .result        (result),
    .line_valid    (line_valid),
    .check_en      (check_en),
    .expected      (expected),
    .result_errors (result_errors),
    .fwd_errors    (fwd_errors),
    .idle          (idle)
  );

  bind mac_pe mac_pe_sva mac_pe_sva_inst (
    .clk    (clk),
    .rstn   (rstn),
    .en     (en),
    .a      (a),
    .b      (b),
    .a_out  (a_out),
    .b_out  (b_out),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Drive one repetition of a file line, first only on its first repetition
  task automatic apply_line(input int idx, input int rep, input int reps);
    int base;
    base       = idx * COLS;
    en         = stim[base][0];
    first      = stim[base+1][0] && (rep == 0);
    a          = stim[base+2][OPERAND_W-1:0];
    b          = stim[base+3][OPERAND_W-1:0];
    expected   = stim[base+4][ACC_W-1:0];
    line_valid = stim[base][0];
    check_en   = (rep == reps - 1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rstn       = 1'b0;
    en         = 1'b0;
    first      = 1'b0;
    a          = '0;
    b          = '0;
    line_valid = 1'b0;
    check_en   = 1'b0;
    expected   = '0;
    for (int i = 0; i < MAX_LINES * COLS; i++) begin
      stim[i] = '0;
    end
    $readmemh("testbench/mac_input.txt", stim);

    // A line with zero repetitions ends the list
    n_lines = 0;
    applied = 0;
    while (n_lines < MAX_LINES && stim[n_lines*COLS+5] != 0) begin
      applied += stim[n_lines*COLS+5];
      n_lines++;
    end
    limit = RESET_CYCLES + applied + 64;

    repeat (RESET_CYCLES) @(negedge clk);
    rstn = 1'b1;

    for (int l = 0; l < n_lines; l++) begin
      for (int r = 0; r < stim[l*COLS+5]; r++) begin
        @(negedge clk);
        apply_line(l, r, stim[l*COLS+5]);
      end
    end

    // Keep enable high so the last pairs drain
    @(negedge clk);
    en         = 1'b1;
    first      = 1'b0;
    a          = '0;
    b          = '0;
    line_valid = 1'b0;
    check_en   = 1'b0;
    while (!idle) @(negedge clk);

    $display("Error counts: result %0d, forwarding %0d", result_errors, fwd_errors);
    if (result_errors + fwd_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, the PE pipeline did not drain", cycles);
      $display("Test failures found");
      $finish;
    end
  end

endmodule

`default_nettype wire
